//--- all.f
hw/gateway_pkg.sv
hw/tag_boot_rom.sv
hw/tag_trace_replay.sv
hw/tag_master.sv
hw/link_hub.sv
hw/gateway_top.sv
sim/tb_gateway.sv

//--- hw/gateway_pkg.sv
package gateway_pkg;

  ////////////////////
  // Widths and counts

  parameter int LINK_W        = 9;
  parameter int NUM_LINKS     = 4;
  parameter int LINK_IDX_W    = 2;
  parameter int CLIENT_ID_W   = 1;
  parameter int TAG_PAYLOAD_W = 8;
  // Start bit, client id, payload
  parameter int TAG_PKT_BITS  = 1 + CLIENT_ID_W + TAG_PAYLOAD_W;
  parameter int ROM_ADDR_W    = 4;

  ////////////////////
  // Boot trace

  typedef enum logic [1:0]
  {
    op_nop  = 2'd0,
    op_send = 2'd1,
    op_wait = 2'd2,
    op_done = 2'd3
  } tag_op_e;

  typedef struct packed
  {
    logic [CLIENT_ID_W-1:0]   id;
    logic [TAG_PAYLOAD_W-1:0] payload;
  } tag_pkt_s;

  typedef struct packed
  {
    tag_op_e  op;
    tag_pkt_s pkt;
  } tag_rom_entry_s;

  ////////////////////
  // Links and client registers

  typedef struct packed
  {
    logic              v;
    logic [LINK_W-1:0] data;
  } link_word_s;

  // Client 0 is route_map, client 1 is link_en
  typedef struct packed
  {
    logic [NUM_LINKS-1:0][LINK_IDX_W-1:0] route_map;
    logic [NUM_LINKS-1:0]                 link_en;
  } tag_lines_s;

endpackage

//--- hw/gateway_top.sv
`timescale 1ns/10ps

module gateway_top
  #(parameter int NUM_LINKS  = gateway_pkg::NUM_LINKS
   ,parameter int ROM_ADDR_W = gateway_pkg::ROM_ADDR_W
   )
  (input  logic                                    clk_i
  ,input  logic                                    reset_i

  ,input  logic                                    host_v_i
  ,input  gateway_pkg::tag_pkt_s                   host_pkt_i
  ,output logic                                    host_ready_o
  ,output logic                                    done_o

  ,input  gateway_pkg::link_word_s [NUM_LINKS-1:0] phys_in_i
  ,output gateway_pkg::link_word_s [NUM_LINKS-1:0] log_out_o
  ,input  gateway_pkg::link_word_s [NUM_LINKS-1:0] log_in_i
  ,output gateway_pkg::link_word_s [NUM_LINKS-1:0] phys_out_o
  );

  import gateway_pkg::*;

  logic [ROM_ADDR_W-1:0] rom_addr_lo;
  tag_rom_entry_s        rom_entry_lo;
  logic                  tag_en_lo;
  logic                  tag_data_lo;
  tag_lines_s            tag_lines_lo;

  ////////////////////
  // Boot trace and tag bus

  tag_boot_rom #(.ROM_ADDR_W(ROM_ADDR_W)) u_rom
    (.addr_i (rom_addr_lo)
    ,.entry_o(rom_entry_lo)
    );

  tag_trace_replay #(.ROM_ADDR_W(ROM_ADDR_W)) u_replay
    (.clk_i       (clk_i)
    ,.reset_i     (reset_i)
    ,.rom_addr_o  (rom_addr_lo)
    ,.rom_entry_i (rom_entry_lo)
    ,.host_v_i    (host_v_i)
    ,.host_pkt_i  (host_pkt_i)
    ,.host_ready_o(host_ready_o)
    ,.tag_en_o    (tag_en_lo)
    ,.tag_data_o  (tag_data_lo)
    ,.done_o      (done_o)
    );

  tag_master u_master
    (.clk_i      (clk_i)
    ,.reset_i    (reset_i)
    ,.tag_en_i   (tag_en_lo)
    ,.tag_data_i (tag_data_lo)
    ,.tag_lines_o(tag_lines_lo)
    );

  ////////////////////
  // Link mapping

  link_hub #(.NUM_LINKS(NUM_LINKS)) u_hub
    (.clk_i      (clk_i)
    ,.reset_i    (reset_i)
    ,.tag_lines_i(tag_lines_lo)
    ,.init_done_i(done_o)
    ,.phys_in_i  (phys_in_i)
    ,.log_out_o  (log_out_o)
    ,.log_in_i   (log_in_i)
    ,.phys_out_o (phys_out_o)
    );

endmodule

//--- hw/link_hub.sv
`timescale 1ns/10ps

module link_hub
  #(parameter int NUM_LINKS = gateway_pkg::NUM_LINKS)
  (input  logic                                    clk_i
  ,input  logic                                    reset_i

  ,input  gateway_pkg::tag_lines_s                 tag_lines_i
  ,input  logic                                    init_done_i

  ,input  gateway_pkg::link_word_s [NUM_LINKS-1:0] phys_in_i
  ,output gateway_pkg::link_word_s [NUM_LINKS-1:0] log_out_o

  ,input  gateway_pkg::link_word_s [NUM_LINKS-1:0] log_in_i
  ,output gateway_pkg::link_word_s [NUM_LINKS-1:0] phys_out_o
  );

  import gateway_pkg::*;

  link_word_s [NUM_LINKS-1:0] log_nxt;
  link_word_s [NUM_LINKS-1:0] phys_nxt;
  link_word_s [NUM_LINKS-1:0] log_out_r;
  link_word_s [NUM_LINKS-1:0] phys_out_r;

  assign log_out_o  = log_out_r;
  assign phys_out_o = phys_out_r;

  ////////////////////
  // Physical to logical

  always_comb
  begin
    for (int i = 0; i < NUM_LINKS; i++)
    begin
      log_nxt[i]   = phys_in_i[tag_lines_i.route_map[i]];
      log_nxt[i].v = log_nxt[i].v && tag_lines_i.link_en[i] && init_done_i;
    end
  end

  ////////////////////
  // Logical to physical

  // Walk down so the lowest enabled logical link wins
  always_comb
  begin
    for (int j = 0; j < NUM_LINKS; j++)
    begin
      phys_nxt[j] = '0;
      for (int i = NUM_LINKS - 1; i >= 0; i--)
      begin
        if (tag_lines_i.link_en[i] && (tag_lines_i.route_map[i] == LINK_IDX_W'(j)))
          phys_nxt[j] = log_in_i[i];
      end
      phys_nxt[j].v = phys_nxt[j].v && init_done_i;
    end
  end

  // One cycle through, valids cleared on reset
  always_ff @(posedge clk_i)
  begin
    log_out_r  <= log_nxt;
    phys_out_r <= phys_nxt;
    if (reset_i)
    begin
      for (int k = 0; k < NUM_LINKS; k++)
      begin
        log_out_r[k].v  <= 1'b0;
        phys_out_r[k].v <= 1'b0;
      end
    end
  end

endmodule

//--- hw/tag_boot_rom.sv
`timescale 1ns/10ps

module tag_boot_rom
  #(parameter int ROM_ADDR_W = gateway_pkg::ROM_ADDR_W)
  (input  logic [ROM_ADDR_W-1:0]     addr_i
  ,output gateway_pkg::tag_rom_entry_s entry_o
  );

  import gateway_pkg::*;

  // Fixed boot trace, nop past the end
  always_comb
  begin
    entry_o = '0;
    case (addr_i)
      ROM_ADDR_W'(0):
      begin
        // Identity route map
        entry_o.op          = op_send;
        entry_o.pkt.id      = CLIENT_ID_W'(0);
        entry_o.pkt.payload = 8'hE4;
      end
      ROM_ADDR_W'(1):
      begin
        entry_o.op          = op_wait;
        entry_o.pkt.payload = TAG_PAYLOAD_W'(3);
      end
      ROM_ADDR_W'(2):
      begin
        // All links on
        entry_o.op          = op_send;
        entry_o.pkt.id      = CLIENT_ID_W'(1);
        entry_o.pkt.payload = 8'h0F;
      end
      ROM_ADDR_W'(3):
        entry_o.op = op_done;
      default:
        entry_o.op = op_nop;
    endcase
  end

endmodule

//--- hw/tag_master.sv
`timescale 1ns/10ps

module tag_master
  (input  logic                    clk_i
  ,input  logic                    reset_i

  ,input  logic                    tag_en_i
  ,input  logic                    tag_data_i

  ,output gateway_pkg::tag_lines_s tag_lines_o
  );

  import gateway_pkg::*;

  // Id and payload bits after the start bit
  localparam int PKT_W = TAG_PKT_BITS - 1;
  localparam int CNT_W = $clog2(TAG_PKT_BITS);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(PKT_W - 1);

  typedef enum logic
  {
    st_idle,
    st_shift
  } state_e;

  state_e           state_r;
  logic [CNT_W-1:0] bit_cnt_r;
  logic [PKT_W-2:0] shift_r;
  tag_lines_s       lines_r;

  tag_pkt_s rx_pkt;
  logic     rx_last;

  assign tag_lines_o = lines_r;

  // Final bit is taken straight off the bus
  assign rx_pkt  = tag_pkt_s'({shift_r, tag_data_i});
  assign rx_last = (state_r == st_shift) && tag_en_i && (bit_cnt_r == BIT_LAST);

  always_ff @(posedge clk_i)
  begin
    if ((state_r == st_shift) && tag_en_i)
      shift_r <= {shift_r[PKT_W-3:0], tag_data_i};
  end

  ////////////////////
  // Receive FSM and client registers

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r   <= st_idle;
      bit_cnt_r <= '0;
      // Identity map, links off
      for (int i = 0; i < NUM_LINKS; i++)
        lines_r.route_map[i] <= LINK_IDX_W'(i);
      lines_r.link_en <= '0;
    end
    else
    begin
      case (state_r)
        st_idle:
        begin
          if (tag_en_i && tag_data_i)
          begin
            bit_cnt_r <= '0;
            state_r   <= st_shift;
          end
        end
        st_shift:
        begin
          if (tag_en_i)
            bit_cnt_r <= bit_cnt_r + 1'b1;
          if (rx_last)
          begin
            state_r <= st_idle;
            case (rx_pkt.id)
              CLIENT_ID_W'(0): lines_r.route_map <= rx_pkt.payload;
              default:         lines_r.link_en   <= rx_pkt.payload[NUM_LINKS-1:0];
            endcase
          end
        end
        default:
          state_r <= st_idle;
      endcase
    end
  end

endmodule

//--- hw/tag_trace_replay.sv
`timescale 1ns/10ps

module tag_trace_replay
  #(parameter int ROM_ADDR_W = gateway_pkg::ROM_ADDR_W)
  (input  logic                        clk_i
  ,input  logic                        reset_i

  ,output logic [ROM_ADDR_W-1:0]       rom_addr_o
  ,input  gateway_pkg::tag_rom_entry_s rom_entry_i

  ,input  logic                        host_v_i
  ,input  gateway_pkg::tag_pkt_s       host_pkt_i
  ,output logic                        host_ready_o

  ,output logic                        tag_en_o
  ,output logic                        tag_data_o

  ,output logic                        done_o
  );

  import gateway_pkg::*;

  localparam int CNT_W = $clog2(TAG_PKT_BITS);
  localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(TAG_PKT_BITS - 1);

  typedef enum logic [2:0]
  {
    st_fetch,
    st_send,
    st_wait,
    st_done_idle,
    st_host_send
  } state_e;

  state_e                   state_r;
  logic [ROM_ADDR_W-1:0]    rom_addr_r;
  logic [CNT_W-1:0]         bit_cnt_r;
  logic [TAG_PAYLOAD_W-1:0] wait_cnt_r;
  logic                     done_r;
  logic [TAG_PKT_BITS-1:0]  shift_r;

  logic     host_accept;
  logic     load_pkt;
  tag_pkt_s load_src;

  assign rom_addr_o   = rom_addr_r;
  assign done_o       = done_r;
  assign host_ready_o = done_r && (state_r == st_done_idle);
  assign host_accept  = host_v_i && host_ready_o;

  assign tag_en_o   = (state_r == st_send) || (state_r == st_host_send);
  assign tag_data_o = shift_r[TAG_PKT_BITS-1];

  ////////////////////
  // Packet serializer

  assign load_pkt = ((state_r == st_fetch) && (rom_entry_i.op == op_send)) || host_accept;
  assign load_src = (state_r == st_fetch) ? rom_entry_i.pkt : host_pkt_i;

  // MSB first, start bit leads
  always_ff @(posedge clk_i)
  begin
    if (load_pkt)
      shift_r <= {1'b1, load_src};
    else if (tag_en_o)
      shift_r <= {shift_r[TAG_PKT_BITS-2:0], 1'b0};
  end

  ////////////////////
  // Sequencer

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r    <= st_fetch;
      rom_addr_r <= '0;
      bit_cnt_r  <= '0;
      wait_cnt_r <= '0;
      done_r     <= 1'b0;
    end
    else
    begin
      case (state_r)
        st_fetch:
        begin
          // ROM pointer freezes on op_done
          if (rom_entry_i.op != op_done)
            rom_addr_r <= rom_addr_r + 1'b1;
          case (rom_entry_i.op)
            op_send:
            begin
              bit_cnt_r <= '0;
              state_r   <= st_send;
            end
            op_wait:
            begin
              if (rom_entry_i.pkt.payload != '0)
              begin
                wait_cnt_r <= rom_entry_i.pkt.payload;
                state_r    <= st_wait;
              end
            end
            op_done:
              state_r <= st_done_idle;
            default:
              state_r <= st_fetch;
          endcase
        end
        st_send, st_host_send:
        begin
          bit_cnt_r <= bit_cnt_r + 1'b1;
          if (bit_cnt_r == BIT_LAST)
            state_r <= (state_r == st_send) ? st_fetch : st_done_idle;
        end
        st_wait:
        begin
          wait_cnt_r <= wait_cnt_r - 1'b1;
          if (wait_cnt_r == TAG_PAYLOAD_W'(1))
            state_r <= st_fetch;
        end
        st_done_idle:
        begin
          done_r <= 1'b1;
          if (host_accept)
          begin
            bit_cnt_r <= '0;
            state_r   <= st_host_send;
          end
        end
        default:
          state_r <= st_fetch;
      endcase
    end
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the gateway testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
  --top-module tb_gateway -Mdir obj_dir -o tb_gateway -f all.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_gateway > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Something failed" "$log"; then
  exit 1
fi
exit 0

//--- sim/tb_gateway.sv
`timescale 1ns/10ps

module tb_gateway;

  import gateway_pkg::*;

  localparam int CLK_HALF     = 5;
  localparam int RESET_CYCLES = 4;
  localparam int BOOT_LIMIT   = 40;
  localparam int CHECK_CYCLES = 200;
  localparam int HOST_LIMIT   = 4 * TAG_PKT_BITS;
  // Boot, 900 check cycles and six host packets come to about 1000 cycles
  localparam int MAX_CYCLES   = 4000;

  logic       clk_i;
  logic       reset_i;
  logic       host_v_i;
  tag_pkt_s   host_pkt_i;
  logic       host_ready_o;
  logic       done_o;
  link_word_s [NUM_LINKS-1:0] phys_in_i;
  link_word_s [NUM_LINKS-1:0] log_out_o;
  link_word_s [NUM_LINKS-1:0] log_in_i;
  link_word_s [NUM_LINKS-1:0] phys_out_o;

  // Inputs seen by the hub at the last rising edge
  link_word_s [NUM_LINKS-1:0] phys_prev;
  link_word_s [NUM_LINKS-1:0] log_prev;

  // Reference copy of the client registers
  logic [NUM_LINKS-1:0][LINK_IDX_W-1:0] mdl_route;
  logic [NUM_LINKS-1:0]                 mdl_en;

  integer seed;
  int     cycle_cnt;
  int     test_errs;
  int     total_errs;
  int     tests_run;
  int     tests_failed;
  int     check_cnt;

  gateway_top #(.NUM_LINKS(NUM_LINKS), .ROM_ADDR_W(ROM_ADDR_W)) u_gateway_top
    (.clk_i       (clk_i)
    ,.reset_i     (reset_i)
    ,.host_v_i    (host_v_i)
    ,.host_pkt_i  (host_pkt_i)
    ,.host_ready_o(host_ready_o)
    ,.done_o      (done_o)
    ,.phys_in_i   (phys_in_i)
    ,.log_out_o   (log_out_o)
    ,.log_in_i    (log_in_i)
    ,.phys_out_o  (phys_out_o)
    );

  initial
  begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES)
    begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("Run stopped at the limit of %0d cycles, a test hung", MAX_CYCLES);
    $display("Something failed");
    $finish;
  end

  ////////////////////
  // Stimulus helpers

  task automatic drive_links();
    logic [31:0] r;
    for (int i = 0; i < NUM_LINKS; i++)
    begin
      r = $random(seed);
      phys_in_i[i] = r[$bits(link_word_s)-1:0];
      r = $random(seed);
      log_in_i[i] = r[$bits(link_word_s)-1:0];
    end
    phys_prev = phys_in_i;
    log_prev  = log_in_i;
  endtask

  task automatic step();
    @(negedge clk_i);
    drive_links();
  endtask

  function automatic logic [TAG_PAYLOAD_W-1:0] random_route();
    logic [31:0]              r;
    logic [TAG_PAYLOAD_W-1:0] map;
    logic                     rep;
    r   = $random(seed);
    map = r[TAG_PAYLOAD_W-1:0];
    rep = 1'b0;
    for (int a = 0; a < NUM_LINKS; a++)
      for (int b = a + 1; b < NUM_LINKS; b++)
        if (map[2*a +: 2] == map[2*b +: 2])
          rep = 1'b1;
    // Force a shared physical link
    if (!rep)
      map[5:4] = map[1:0];
    return map;
  endfunction

  // Holds host_v_i until the packet is taken, returns the cycles spent pending
  task automatic host_accept(input tag_pkt_s pkt, output int waited);
    host_v_i   = 1'b1;
    host_pkt_i = pkt;
    waited     = 0;
    while (!host_ready_o && waited < HOST_LIMIT)
    begin
      step();
      waited++;
    end
    if (!host_ready_o)
      report_problem("host packet was never accepted");
    step();
    host_v_i = 1'b0;
  endtask

  task automatic wait_host_idle();
    int n;
    n = 0;
    while (!host_ready_o && n < HOST_LIMIT)
    begin
      step();
      n++;
    end
    if (!host_ready_o)
      report_problem("host port did not become ready after a packet");
  endtask

  ////////////////////
  // Checks

  task automatic report_problem(input string msg);
    $display("%0t: %s", $time, msg);
    test_errs++;
  endtask

  task automatic compare_word(input string name, input int idx,
                              input link_word_s got, input link_word_s exp);
    check_cnt++;
    if (got.v !== exp.v || (exp.v && got.data !== exp.data))
    begin
      $display("FAIL %0t: %s[%0d] got v=%0b data=%h, expected v=%0b data=%h",
               $time, name, idx, got.v, got.data, exp.v, exp.data);
      test_errs++;
    end
  endtask

  task automatic check_gated();
    link_word_s zero;
    zero = '0;
    for (int i = 0; i < NUM_LINKS; i++)
    begin
      compare_word("log_out_o", i, log_out_o[i], zero);
      compare_word("phys_out_o", i, phys_out_o[i], zero);
    end
  endtask

  task automatic check_hub(input bit chk_log, input bit chk_phys);
    link_word_s exp;
    bit         found;
    for (int i = 0; i < NUM_LINKS && chk_log; i++)
    begin
      exp   = phys_prev[mdl_route[i]];
      exp.v = exp.v && mdl_en[i];
      compare_word("log_out_o", i, log_out_o[i], exp);
    end
    for (int j = 0; j < NUM_LINKS && chk_phys; j++)
    begin
      exp   = '0;
      found = 1'b0;
      for (int i = 0; i < NUM_LINKS; i++)
        if (!found && mdl_en[i] && mdl_route[i] == LINK_IDX_W'(j))
        begin
          exp   = log_prev[i];
          found = 1'b1;
        end
      compare_word("phys_out_o", j, phys_out_o[j], exp);
    end
  endtask

  task automatic run_checks(input int cycles, input bit chk_log, input bit chk_phys);
    repeat (cycles)
    begin
      @(negedge clk_i);
      check_hub(chk_log, chk_phys);
      drive_links();
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    total_errs += test_errs;
    if (test_errs == 0)
      $display("test %0d %s: passed", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, test_errs);
    end
    test_errs = 0;
  endtask

  ////////////////////
  // Test sequence

  initial
  begin
    tag_pkt_s                 pkt;
    tag_pkt_s                 burst [4];
    logic [31:0]              r;
    logic [TAG_PAYLOAD_W-1:0] en_byte;
    int                       n;
    int                       waited;

    seed         = 4012;
    reset_i      = 1'b1;
    host_v_i     = 1'b0;
    host_pkt_i   = '0;
    phys_in_i    = '0;
    log_in_i     = '0;
    phys_prev    = '0;
    log_prev     = '0;
    mdl_route    = 8'hE4;
    mdl_en       = '0;
    test_errs    = 0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;
    check_cnt    = 0;

    repeat (RESET_CYCLES) @(negedge clk_i);
    reset_i = 1'b0;

    // Gating during boot replay
    if (done_o !== 1'b0 || host_ready_o !== 1'b0)
    begin
      $display("FAIL %0t: done_o=%0b host_ready_o=%0b after reset, expected 0",
               $time, done_o, host_ready_o);
      test_errs++;
    end
    n = 0;
    while (!done_o && n < BOOT_LIMIT)
    begin
      check_gated();
      drive_links();
      @(negedge clk_i);
      n++;
    end
    if (!done_o)
      report_problem("done_o did not rise within 40 cycles of reset");
    finish_test("boot gating");

    // Boot trace leaves identity map, all links on
    drive_links();
    mdl_en = 4'hF;
    run_checks(CHECK_CYCLES, 1'b1, 1'b1);
    finish_test("identity map");

    pkt.id      = 1'b0;
    pkt.payload = random_route();
    host_accept(pkt, waited);
    wait_host_idle();
    mdl_route = pkt.payload;
    run_checks(CHECK_CYCLES, 1'b1, 1'b0);
    finish_test("random route map");

    run_checks(CHECK_CYCLES, 1'b0, 1'b1);
    finish_test("reverse priority");

    r       = $random(seed);
    en_byte = r[TAG_PAYLOAD_W-1:0];
    if (en_byte[3:0] == 4'hF)
      en_byte[3:0] = 4'hA;
    pkt.id      = 1'b1;
    pkt.payload = en_byte;
    host_accept(pkt, waited);
    wait_host_idle();
    mdl_en = en_byte[NUM_LINKS-1:0];
    run_checks(CHECK_CYCLES, 1'b1, 1'b1);
    finish_test("enable mask");

    // Back-to-back host packets, the last two must stick
    burst[0].id      = 1'b0;
    burst[0].payload = random_route();
    r                = $random(seed);
    burst[1].id      = 1'b1;
    burst[1].payload = r[TAG_PAYLOAD_W-1:0];
    burst[2].id      = 1'b0;
    burst[2].payload = random_route();
    // Every logical link moves so a lost route packet shows
    for (int a = 0; a < NUM_LINKS; a++)
      if (burst[2].payload[2*a +: 2] == burst[0].payload[2*a +: 2])
        burst[2].payload[2*a +: 2] = ~burst[0].payload[2*a +: 2];
    r                = $random(seed);
    burst[3].id      = 1'b1;
    burst[3].payload = r[TAG_PAYLOAD_W-1:0];
    if (burst[3].payload[3:0] == burst[1].payload[3:0])
      burst[3].payload[3:0] = ~burst[1].payload[3:0];
    // At least one link on
    if (burst[3].payload[3:0] == 4'h0)
      burst[3].payload[3:0] = ~burst[1].payload[3:0] | 4'h1;
    for (int k = 0; k < 4; k++)
    begin
      host_accept(burst[k], waited);
      if (k > 0 && waited == 0)
        report_problem("host_ready_o was high while a packet was serializing");
    end
    wait_host_idle();
    mdl_route = burst[2].payload;
    mdl_en    = burst[3].payload[NUM_LINKS-1:0];
    run_checks(CHECK_CYCLES / 2, 1'b1, 1'b1);
    finish_test("host back-pressure");

    $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, check_cnt, total_errs);
    if (total_errs == 0 && tests_failed == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule
